//--- oflow_core.f
verilog/oflow_pkg.sv
verilog/oflow_reg_file.sv
verilog/oflow_frame_buffer.sv
verilog/oflow_similarity.sv
verilog/oflow_match_fsm.sv
verilog/oflow_core.sv
dv/oflow_core_tb.sv

//--- dv/oflow_core_tb.sv
/*
 * Testbench of the object-flow tracking core.
 * Streams frames of boxes into the DUT and keeps its own model of the
 * previous frame, the current frame and the next fresh id. Concurrent
 * assertions check the id on every output handshake, the output hold
 * under back-pressure and the input ready. Run with oflow_core_tb as top.
 */
module oflow_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TOTAL_BOXES    = 49; // all frames together
	localparam int TIMEOUT_CYCLES = TOTAL_BOXES * (oflow_pkg::MAX_BBOX + 8) * 4 + 200;

	logic                          clk, rst_i;
	logic                          cfg_we_i;
	oflow_pkg::cfg_addr_e          cfg_addr_i;
	logic [oflow_pkg::SCORE_W-1:0] cfg_wdata_i;
	logic                          bbox_valid_i, bbox_last_i, bbox_ready_o;
	oflow_pkg::bbox_t              bbox_i;
	logic                          id_valid_o, id_new_o, id_ready_i;
	logic [oflow_pkg::ID_W-1:0]    id_o;

	// ------------------------------------------------------------------------
	// reference model state
	// ------------------------------------------------------------------------
	oflow_pkg::bbox_t              prev_box [oflow_pkg::MAX_BBOX];
	logic [oflow_pkg::ID_W-1:0]    prev_id  [oflow_pkg::MAX_BBOX];
	oflow_pkg::bbox_t              cur_box  [oflow_pkg::MAX_BBOX];
	logic [oflow_pkg::ID_W-1:0]    cur_id   [oflow_pkg::MAX_BBOX];
	int                            prev_cnt, cur_cnt;
	logic [oflow_pkg::ID_W-1:0]    next_fresh;     // model of the id counter
	oflow_pkg::weights_t           model_w;
	logic [oflow_pkg::SCORE_W-1:0] model_thresh;
	logic [oflow_pkg::ID_W-1:0]    exp_id;         // expectation for the box in flight
	logic                          exp_new;
	logic                          box_open;       // box accepted, id not yet taken
	logic                          ready_exp;      // expected bbox_ready_o

	integer  seed = 32'h662d5bb2;
	string   test_name = "reset";
	int      id_errors, hold_errors, ready_errors, ids_done, cycles;
	int      shuffle [5] = '{3, 0, 4, 1, 2};
	oflow_pkg::bbox_t tmp_box;

	oflow_core dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// one box at a time, ready again once its id is taken
	always @(posedge clk) begin
		if (rst_i) begin
			box_open  <= 1'b0;
			ready_exp <= 1'b0;
		end else if (bbox_valid_i && bbox_ready_o) begin
			box_open  <= 1'b1;
			ready_exp <= 1'b0;
		end else if (id_valid_o && id_ready_i) begin
			box_open  <= 1'b0;
			ready_exp <= 1'b1;
		end else begin
			ready_exp <= !box_open; // first cycle after reset
		end
	end

	// ------------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------------
	a_id_check: assert property (
		@(posedge clk) disable iff (rst_i)
		(id_valid_o && id_ready_i) |-> (id_o == exp_id && id_new_o == exp_new)
	) else begin
		id_errors++;
		$display("FAILED %s: expected id %0d new %0b, actual id %0d new %0b", test_name,
			exp_id, exp_new, $sampled(id_o), $sampled(id_new_o));
	end

	a_hold_check: assert property (
		@(posedge clk) disable iff (rst_i)
		(id_valid_o && !id_ready_i) |=> (id_valid_o && $stable(id_o) && $stable(id_new_o))
	) else begin
		hold_errors++;
		$display("ERROR in %s: id output changed while id_ready_i was low", test_name);
	end

	a_ready_check: assert property (
		@(posedge clk) disable iff (rst_i)
		bbox_ready_o == ready_exp
	) else begin
		ready_errors++;
		$display("FAILED %s: expected bbox_ready_o %0b, actual %0b", test_name,
			$sampled(ready_exp), $sampled(bbox_ready_o));
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic oflow_pkg::bbox_t make_box(int x, int y, int w, int h, int c);
		oflow_pkg::bbox_t b;
		b.x = 8'(x);
		b.y = 8'(y);
		b.w = 8'(w);
		b.h = 8'(h);
		b.color = 8'(c);
		return b;
	endfunction

	function automatic oflow_pkg::bbox_t base_box(int k); // well spread, neighbours > 100 apart
		return make_box(20 + 40 * k, 30 + 30 * k, 16 + 4 * k, 16 + 2 * k, 10 + 30 * k);
	endfunction

	function automatic oflow_pkg::bbox_t random_box();
		return make_box($random(seed), $random(seed), $random(seed), $random(seed),
			$random(seed));
	endfunction

	function automatic oflow_pkg::bbox_t jitter_box(oflow_pkg::bbox_t b); // small moves, 8-bit wrap
		return make_box(b.x + {$random(seed)} % 4, b.y + {$random(seed)} % 4,
			b.w + {$random(seed)} % 4, b.h + {$random(seed)} % 4, b.color + {$random(seed)} % 4);
	endfunction

	function automatic int abs_diff(logic [7:0] a, logic [7:0] b);
		int d;
		d = int'(a) - int'(b);
		return (d < 0) ? -d : d;
	endfunction

	// weighted distance, sum over the five fields
	function automatic int box_distance(oflow_pkg::bbox_t a, oflow_pkg::bbox_t b);
		return int'(model_w.x) * abs_diff(a.x, b.x) + int'(model_w.y) * abs_diff(a.y, b.y)
			+ int'(model_w.w) * abs_diff(a.w, b.w) + int'(model_w.h) * abs_diff(a.h, b.h)
			+ int'(model_w.color) * abs_diff(a.color, b.color);
	endfunction

	task automatic predict(input oflow_pkg::bbox_t b);
		int best, s;
		logic [oflow_pkg::ID_W-1:0] best_id;
		best    = 32'h7fffffff;
		best_id = '0;
		for (int i = 0; i < prev_cnt; i++) begin
			s = box_distance(b, prev_box[i]);
			if (s < best) begin // strict, lowest index wins ties
				best    = s;
				best_id = prev_id[i];
			end
		end
		if (prev_cnt > 0 && best < int'(model_thresh)) begin
			exp_id  = best_id;
			exp_new = 1'b0;
		end else begin
			exp_id  = next_fresh;
			exp_new = 1'b1;
		end
	endtask

	// entered and left just after a falling edge
	task automatic send_box(input oflow_pkg::bbox_t b, input logic last);
		logic was_ready, hs;
		predict(b);
		bbox_i       = b;
		bbox_last_i  = last;
		bbox_valid_i = 1'b1;
		do begin
			was_ready = bbox_ready_o; // registered, stable until the rising edge
			@(negedge clk);
		end while (!was_ready);
		bbox_valid_i = 1'b0;
		do begin
			id_ready_i = ({$random(seed)} % 10) < 7; // ~70 % ready
			hs = id_valid_o && id_ready_i;
			@(negedge clk);
		end while (!hs);
		cur_box[cur_cnt] = b; // history update mirrors the handshake
		cur_id[cur_cnt]  = exp_id;
		cur_cnt++;
		ids_done++;
		if (exp_new)
			next_fresh++;
		if (last) begin
			for (int i = 0; i < cur_cnt; i++) begin
				prev_box[i] = cur_box[i];
				prev_id[i]  = cur_id[i];
			end
			prev_cnt = cur_cnt;
			cur_cnt  = 0;
		end
	endtask

	task automatic write_cfg(input oflow_pkg::cfg_addr_e addr, input int data);
		while (!bbox_ready_o)
			@(negedge clk);
		cfg_we_i    = 1'b1;
		cfg_addr_i  = addr;
		cfg_wdata_i = 16'(data);
		@(negedge clk);
		cfg_we_i = 1'b0;
		case (addr)
			oflow_pkg::CFG_W_X:     model_w.x     = 4'(data);
			oflow_pkg::CFG_W_Y:     model_w.y     = 4'(data);
			oflow_pkg::CFG_W_W:     model_w.w     = 4'(data);
			oflow_pkg::CFG_W_H:     model_w.h     = 4'(data);
			oflow_pkg::CFG_W_COLOR: model_w.color = 4'(data);
			default:                model_thresh  = 16'(data);
		endcase
	endtask

	// ------------------------------------------------------------------------
	// timeout
	// ------------------------------------------------------------------------
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("ERROR: run hung in %s after %0d cycles", test_name, cycles);
		$display("errors: id %0d, hold %0d, ready %0d", id_errors, hold_errors, ready_errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		rst_i = 1'b1;
		cfg_we_i = 1'b0;
		cfg_addr_i = oflow_pkg::CFG_W_X;
		cfg_wdata_i = '0;
		bbox_valid_i = 1'b0;
		bbox_i = '0;
		bbox_last_i = 1'b0;
		id_ready_i = 1'b0;
		model_w = {5{oflow_pkg::WEIGHT_RST}};
		model_thresh = oflow_pkg::THRESH_RST;
		next_fresh = 8'd1;
		prev_cnt = 0;
		cur_cnt = 0;
		id_errors = 0;
		hold_errors = 0;
		ready_errors = 0;
		ids_done = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		test_name = "first_frame"; // ids 1..5, all fresh
		for (int k = 0; k < 5; k++)
			send_box(base_box(k), k == 4);

		test_name = "shuffled_frame"; // each box inherits its source id
		for (int k = 0; k < 5; k++) begin
			tmp_box = base_box(shuffle[k]);
			send_box(make_box(tmp_box.x + 2, tmp_box.y - 1, tmp_box.w, tmp_box.h,
				tmp_box.color + 1), k == 4);
		end

		test_name = "fresh_ids";
		send_box(make_box(250, 250, 200, 200, 250), 1'b0); // far from all
		send_box(make_box(86, 29, 16, 16, 11), 1'b0);      // exactly 64 off box 0
		send_box(make_box(102, 89, 24, 20, 71), 1'b1);     // exact copy of box 2

		test_name = "config_weights";
		write_cfg(oflow_pkg::CFG_W_X, 0);
		write_cfg(oflow_pkg::CFG_THRESH, 10);
		send_box(make_box(152, 89, 24, 20, 71), 1'b0);     // x only, matches
		send_box(make_box(250, 230, 200, 200, 250), 1'b1); // y off by 20, fresh

		test_name = "tie_break";
		write_cfg(oflow_pkg::CFG_W_X, 1);
		write_cfg(oflow_pkg::CFG_THRESH, 64);
		send_box(make_box(40, 200, 30, 30, 120), 1'b0);
		send_box(make_box(40, 200, 30, 30, 120), 1'b1);    // twin, second fresh id

		test_name = "full_frame_stalls"; // first box ties on the twins
		send_box(make_box(40, 200, 30, 30, 120), 1'b0);
		for (int k = 1; k < oflow_pkg::MAX_BBOX; k++)
			send_box(random_box(), k == oflow_pkg::MAX_BBOX - 1);
		for (int k = 0; k < oflow_pkg::MAX_BBOX; k++) begin
			tmp_box = (k % 2 == 0) ? jitter_box(prev_box[(k * 5) % 16]) : random_box();
			send_box(tmp_box, k == oflow_pkg::MAX_BBOX - 1);
		end

		repeat (4) @(negedge clk);
		$display("ids checked %0d, errors: id %0d, hold %0d, ready %0d", ids_done, id_errors,
			hold_errors, ready_errors);
		if (id_errors == 0 && hold_errors == 0 && ready_errors == 0
			&& ids_done == TOTAL_BOXES) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog/oflow_core.sv
/*
 * Top level of the object-flow tracking core.
 * Boxes stream in over a valid/ready port with a last flag per frame,
 * track ids stream out in the same order. Weights and the threshold are
 * set through the config port while the core is idle.
 */
module oflow_core (
	input  logic                          clk,
	input  logic                          rst_i,
	// host config
	input  logic                          cfg_we_i,
	input  oflow_pkg::cfg_addr_e          cfg_addr_i,
	input  logic [oflow_pkg::SCORE_W-1:0] cfg_wdata_i,
	// box stream in
	input  logic                          bbox_valid_i,
	input  oflow_pkg::bbox_t              bbox_i,
	input  logic                          bbox_last_i,
	output logic                          bbox_ready_o,
	// id stream out
	output logic                          id_valid_o,
	output logic [oflow_pkg::ID_W-1:0]    id_o,
	output logic                          id_new_o,
	input  logic                          id_ready_i
);

	// --------------------------------------------------------------------------
	// wires
	// --------------------------------------------------------------------------
	oflow_pkg::weights_t           weights;
	logic [oflow_pkg::SCORE_W-1:0] thresh;
	logic [oflow_pkg::IDX_W-1:0]   rd_idx;
	oflow_pkg::bbox_t              prev_bbox, cur_bbox, wr_bbox;
	logic [oflow_pkg::ID_W-1:0]    prev_id, score_id, wr_id;
	logic [oflow_pkg::CNT_W-1:0]   prev_count;
	logic                          cmp_valid, score_valid, wr_en, swap;
	logic [oflow_pkg::SCORE_W-1:0] score;

	// --------------------------------------------------------------------------
	// instances
	// --------------------------------------------------------------------------
	oflow_reg_file reg_file_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.weights_o   (weights),
		.thresh_o    (thresh)
	);

	oflow_frame_buffer frame_buffer_i (
		.clk          (clk),
		.rst_i        (rst_i),
		.rd_idx_i     (rd_idx),
		.rd_bbox_o    (prev_bbox),
		.rd_id_o      (prev_id),
		.prev_count_o (prev_count),
		.wr_en_i      (wr_en),
		.wr_bbox_i    (wr_bbox),
		.wr_id_i      (wr_id),
		.swap_i       (swap)
	);

	oflow_similarity similarity_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.valid_i     (cmp_valid),
		.cur_bbox_i  (cur_bbox),
		.prev_bbox_i (prev_bbox),
		.prev_id_i   (prev_id),
		.weights_i   (weights),
		.valid_o     (score_valid),
		.score_o     (score),
		.id_o        (score_id)
	);

	oflow_match_fsm match_fsm_i (
		.clk           (clk),
		.rst_i         (rst_i),
		.bbox_valid_i  (bbox_valid_i),
		.bbox_i        (bbox_i),
		.bbox_last_i   (bbox_last_i),
		.bbox_ready_o  (bbox_ready_o),
		.thresh_i      (thresh),
		.prev_count_i  (prev_count),
		.rd_idx_o      (rd_idx),
		.cmp_valid_o   (cmp_valid),
		.cur_bbox_o    (cur_bbox),
		.score_valid_i (score_valid),
		.score_i       (score),
		.score_id_i    (score_id),
		.wr_en_o       (wr_en),
		.wr_bbox_o     (wr_bbox),
		.wr_id_o       (wr_id),
		.swap_o        (swap),
		.id_valid_o    (id_valid_o),
		.id_o          (id_o),
		.id_new_o      (id_new_o),
		.id_ready_i    (id_ready_i)
	);

endmodule

//--- verilog/oflow_match_fsm.sv
/*
 * Match control of the tracking core.
 * Takes one box at a time, scans the previous frame through the scorer,
 * keeps the lowest score and its id, then either inherits that id or
 * hands out a fresh one. The id waits on the output port until taken,
 * and the box is then written into the history.
 */
module oflow_match_fsm (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          bbox_valid_i,
	input  oflow_pkg::bbox_t              bbox_i,
	input  logic                          bbox_last_i,
	output logic                          bbox_ready_o,
	input  logic [oflow_pkg::SCORE_W-1:0] thresh_i,
	input  logic [oflow_pkg::CNT_W-1:0]   prev_count_i,
	output logic [oflow_pkg::IDX_W-1:0]   rd_idx_o,
	output logic                          cmp_valid_o,
	output oflow_pkg::bbox_t              cur_bbox_o,
	input  logic                          score_valid_i,
	input  logic [oflow_pkg::SCORE_W-1:0] score_i,
	input  logic [oflow_pkg::ID_W-1:0]    score_id_i,
	output logic                          wr_en_o,
	output oflow_pkg::bbox_t              wr_bbox_o,
	output logic [oflow_pkg::ID_W-1:0]    wr_id_o,
	output logic                          swap_o,
	output logic                          id_valid_o,
	output logic [oflow_pkg::ID_W-1:0]    id_o,
	output logic                          id_new_o,
	input  logic                          id_ready_i
);

	oflow_pkg::match_state_e       state, state_d;
	oflow_pkg::bbox_t              cur_q;      // box under test
	logic                          last_q;     // box closes its frame
	logic [oflow_pkg::IDX_W-1:0]   scan_idx;
	logic [oflow_pkg::CNT_W-1:0]   rcv_cnt;    // scores seen so far
	logic [oflow_pkg::SCORE_W-1:0] min_score;
	logic [oflow_pkg::ID_W-1:0]    min_id;
	logic [oflow_pkg::ID_W-1:0]    next_id;    // next fresh id
	logic                          accept, out_hs, match, last_score;

	assign accept     = bbox_valid_i && bbox_ready_o;
	assign out_hs     = id_valid_o && id_ready_i;
	assign match      = (min_score < thresh_i); // strictly below
	assign last_score = score_valid_i && (rcv_cnt == prev_count_i - 1'b1);

	// --------------------------------------------------------------------------
	// next state
	// --------------------------------------------------------------------------
	always_comb begin
		state_d = state;
		case (state)
			oflow_pkg::ST_IDLE:
				if (accept)
					state_d = (prev_count_i == '0) ? oflow_pkg::ST_DRAIN : oflow_pkg::ST_SCAN;
			oflow_pkg::ST_SCAN:
				if ({1'b0, scan_idx} == prev_count_i - 1'b1)
					state_d = oflow_pkg::ST_DRAIN; // last read issued
			oflow_pkg::ST_DRAIN:
				if (prev_count_i == '0 || last_score)
					state_d = oflow_pkg::ST_OUT;
			oflow_pkg::ST_OUT:
				if (out_hs)
					state_d = oflow_pkg::ST_IDLE;
			default: state_d = oflow_pkg::ST_IDLE;
		endcase
	end

	// --------------------------------------------------------------------------
	// control registers
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state        <= oflow_pkg::ST_IDLE;
			bbox_ready_o <= 1'b0; // low through reset
			cmp_valid_o  <= 1'b0;
			scan_idx     <= '0;
			rcv_cnt      <= '0;
			last_q       <= 1'b0;
			next_id      <= oflow_pkg::ID_W'(1);
		end else begin
			state        <= state_d;
			bbox_ready_o <= (state_d == oflow_pkg::ST_IDLE);
			cmp_valid_o  <= (state == oflow_pkg::ST_SCAN); // data one cycle behind idx
			if (accept) begin
				scan_idx <= '0;
				rcv_cnt  <= '0;
				last_q   <= bbox_last_i;
			end else begin
				if (state == oflow_pkg::ST_SCAN)
					scan_idx <= scan_idx + 1'b1;
				if (score_valid_i)
					rcv_cnt <= rcv_cnt + 1'b1;
			end
			if (out_hs && !match)
				next_id <= next_id + 1'b1; // fresh id consumed
		end
	end

	// box latch and running minimum, ties keep the lower index
	always_ff @(posedge clk) begin
		if (accept) begin
			cur_q     <= bbox_i;
			min_score <= '1;
		end else if (score_valid_i && score_i < min_score) begin
			min_score <= score_i;
			min_id    <= score_id_i;
		end
	end

	// --------------------------------------------------------------------------
	// outputs
	// --------------------------------------------------------------------------
	assign rd_idx_o   = scan_idx;
	assign cur_bbox_o = cur_q;
	assign id_valid_o = (state == oflow_pkg::ST_OUT);
	assign id_o       = match ? min_id : next_id;
	assign id_new_o   = !match;
	assign wr_en_o    = out_hs;        // history write on the handshake
	assign wr_bbox_o  = cur_q;
	assign wr_id_o    = id_o;
	assign swap_o     = out_hs && last_q;

	a_out_stable: assert property (
		@(posedge clk) disable iff (rst_i)
		(id_valid_o && !id_ready_i) |=> (id_valid_o && $stable(id_o) && $stable(id_new_o))
	) else $error("id output changed while stalled");

	// pipeline must be empty before a new box is taken
	a_no_stray_score: assert property (
		@(posedge clk) disable iff (rst_i)
		(state == oflow_pkg::ST_IDLE) |-> !score_valid_i
	) else $error("score arrived while idle");

endmodule

//--- verilog/oflow_similarity.sv
/*
 * Weighted distance between the current box and one history box.
 * Stage one registers the five absolute field differences, stage two
 * the weighted sum. The id of the history box and the valid bit ride
 * along, so a score appears two cycles after its compare.
 */
module oflow_similarity (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          valid_i,
	input  oflow_pkg::bbox_t              cur_bbox_i,
	input  oflow_pkg::bbox_t              prev_bbox_i,
	input  logic [oflow_pkg::ID_W-1:0]    prev_id_i,
	input  oflow_pkg::weights_t           weights_i,
	output logic                          valid_o,
	output logic [oflow_pkg::SCORE_W-1:0] score_o,
	output logic [oflow_pkg::ID_W-1:0]    id_o
);

	function automatic logic [oflow_pkg::COORD_W-1:0] absdiff(
		input logic [oflow_pkg::COORD_W-1:0] a,
		input logic [oflow_pkg::COORD_W-1:0] b
	);
		return (a > b) ? (a - b) : (b - a);
	endfunction

	// --------------------------------------------------------------------------
	// stage one, field differences
	// --------------------------------------------------------------------------
	logic [oflow_pkg::COORD_W-1:0] diff_q [5]; // x y w h color
	logic [oflow_pkg::ID_W-1:0]    id_s1;
	logic                          valid_s1;
	logic [oflow_pkg::SCORE_W-1:0] wsum;

	always_ff @(posedge clk) begin
		diff_q[0] <= absdiff(cur_bbox_i.x,     prev_bbox_i.x);
		diff_q[1] <= absdiff(cur_bbox_i.y,     prev_bbox_i.y);
		diff_q[2] <= absdiff(cur_bbox_i.w,     prev_bbox_i.w);
		diff_q[3] <= absdiff(cur_bbox_i.h,     prev_bbox_i.h);
		diff_q[4] <= absdiff(cur_bbox_i.color, prev_bbox_i.color);
		id_s1     <= prev_id_i;
	end

	// --------------------------------------------------------------------------
	// stage two, weighted sum
	// --------------------------------------------------------------------------
	// operands widen to SCORE_W in this context, max sum well below 2**16
	assign wsum = diff_q[0] * weights_i.x
	            + diff_q[1] * weights_i.y
	            + diff_q[2] * weights_i.w
	            + diff_q[3] * weights_i.h
	            + diff_q[4] * weights_i.color;

	always_ff @(posedge clk) begin
		score_o <= wsum;
		id_o    <= id_s1;
	end

	// valid pipe
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_s1 <= 1'b0;
			valid_o  <= 1'b0;
		end else begin
			valid_s1 <= valid_i;
			valid_o  <= valid_s1;
		end
	end

endmodule

//--- verilog/oflow_frame_buffer.sv
/*
 * Ping-pong history of boxes and track ids.
 * One bank holds the previous frame and is read by index, the other
 * collects the current frame in arrival order. A swap turns the current
 * bank into the previous one and empties the other for the next frame.
 * Reads come back one cycle after the index.
 */
module oflow_frame_buffer (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic [oflow_pkg::IDX_W-1:0]   rd_idx_i,
	output oflow_pkg::bbox_t              rd_bbox_o,
	output logic [oflow_pkg::ID_W-1:0]    rd_id_o,
	output logic [oflow_pkg::CNT_W-1:0]   prev_count_o,
	input  logic                          wr_en_i,
	input  oflow_pkg::bbox_t              wr_bbox_i,
	input  logic [oflow_pkg::ID_W-1:0]    wr_id_i,
	input  logic                          swap_i
);

	// --------------------------------------------------------------------------
	// storage
	// --------------------------------------------------------------------------
	oflow_pkg::bbox_t             box_mem [2][oflow_pkg::MAX_BBOX];
	logic [oflow_pkg::ID_W-1:0]   id_mem  [2][oflow_pkg::MAX_BBOX];

	logic                          cur_bank;   // bank being filled
	logic [oflow_pkg::CNT_W-1:0]   count [2];  // boxes held per bank
	logic [oflow_pkg::IDX_W-1:0]   wr_ptr;     // next free slot of cur bank

	assign wr_ptr       = count[cur_bank][oflow_pkg::IDX_W-1:0];
	assign prev_count_o = count[!cur_bank];

	// --------------------------------------------------------------------------
	// bank select and counts
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			cur_bank <= 1'b0;
			count[0] <= '0;
			count[1] <= '0;
		end else begin
			if (wr_en_i)
				count[cur_bank] <= count[cur_bank] + 1'b1; // append
			if (swap_i) begin
				// old prev bank becomes the new, empty current bank
				cur_bank         <= !cur_bank;
				count[!cur_bank] <= '0;
			end
		end
	end

	// --------------------------------------------------------------------------
	// memory write and registered read
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			box_mem[cur_bank][wr_ptr] <= wr_bbox_i;
			id_mem[cur_bank][wr_ptr]  <= wr_id_i;
		end
		rd_bbox_o <= box_mem[!cur_bank][rd_idx_i]; // always from prev frame
		rd_id_o   <= id_mem[!cur_bank][rd_idx_i];
	end

	// the sender promises at most MAX_BBOX boxes per frame
	a_no_overflow: assert property (
		@(posedge clk) disable iff (rst_i)
		wr_en_i |-> (count[cur_bank] < oflow_pkg::MAX_BBOX)
	) else $error("history write into a full bank");

endmodule

//--- verilog/oflow_reg_file.sv
/*
 * Configuration registers of the tracking core.
 * The host writes the five field weights and the match threshold through
 * a simple write port. A write lands on the edge where cfg_we_i is high.
 * Weight registers keep only the low WEIGHT_W bits of the write data.
 */
module oflow_reg_file (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            cfg_we_i,
	input  oflow_pkg::cfg_addr_e            cfg_addr_i,
	input  logic [oflow_pkg::SCORE_W-1:0]   cfg_wdata_i,
	output oflow_pkg::weights_t             weights_o,
	output logic [oflow_pkg::SCORE_W-1:0]   thresh_o
);

	logic [oflow_pkg::WEIGHT_W-1:0] wdata_w; // weight slice of the write data

	assign wdata_w = cfg_wdata_i[oflow_pkg::WEIGHT_W-1:0];

	// --------------------------------------------------------------------------
	// address decode and storage
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			weights_o.x     <= oflow_pkg::WEIGHT_RST;
			weights_o.y     <= oflow_pkg::WEIGHT_RST;
			weights_o.w     <= oflow_pkg::WEIGHT_RST;
			weights_o.h     <= oflow_pkg::WEIGHT_RST;
			weights_o.color <= oflow_pkg::WEIGHT_RST;
			thresh_o        <= oflow_pkg::THRESH_RST;
		end else if (cfg_we_i) begin
			case (cfg_addr_i)
				oflow_pkg::CFG_W_X:     weights_o.x     <= wdata_w;
				oflow_pkg::CFG_W_Y:     weights_o.y     <= wdata_w;
				oflow_pkg::CFG_W_W:     weights_o.w     <= wdata_w;
				oflow_pkg::CFG_W_H:     weights_o.h     <= wdata_w;
				oflow_pkg::CFG_W_COLOR: weights_o.color <= wdata_w;
				oflow_pkg::CFG_THRESH:  thresh_o        <= cfg_wdata_i; // full width
				default: ; // unmapped, dropped
			endcase
		end
	end

	// host must stay inside the register map
	a_cfg_addr_legal: assert property (
		@(posedge clk) disable iff (rst_i)
		cfg_we_i |-> (cfg_addr_i <= oflow_pkg::CFG_THRESH)
	) else $error("config write to unmapped address %0d", cfg_addr_i);

endmodule

//--- verilog/oflow_pkg.sv
/*
 * Shared definitions for the object-flow tracking core.
 * Holds the widths and depths, the packed box and weight types, the
 * register map and the match FSM states. Every design file refers to
 * these by scoped names, oflow_pkg::name.
 */
package oflow_pkg;

	// --------------------------------------------------------------------------
	// widths and depths
	// --------------------------------------------------------------------------
	localparam int COORD_W  = 8;  // one box field
	localparam int WEIGHT_W = 4;  // one similarity weight
	localparam int SCORE_W  = 16; // five weighted 8-bit diffs fit with room to spare
	localparam int ID_W     = 8;  // track id
	localparam int MAX_BBOX = 16; // boxes per frame, depth of one bank
	localparam int IDX_W    = 4;  // box index inside a bank
	localparam int CNT_W    = 5;  // box count, 0..MAX_BBOX

	localparam logic [WEIGHT_W-1:0] WEIGHT_RST = 4'd1;
	localparam logic [SCORE_W-1:0]  THRESH_RST = 16'd64;

	// --------------------------------------------------------------------------
	// types
	// --------------------------------------------------------------------------
	// x sits in the top byte, color in the bottom one
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] w;
		logic [COORD_W-1:0] h;
		logic [COORD_W-1:0] color;
	} bbox_t;

	// same field order as the box
	typedef struct packed {
		logic [WEIGHT_W-1:0] x;
		logic [WEIGHT_W-1:0] y;
		logic [WEIGHT_W-1:0] w;
		logic [WEIGHT_W-1:0] h;
		logic [WEIGHT_W-1:0] color;
	} weights_t;

	// host register map
	typedef enum logic [2:0] {
		CFG_W_X     = 3'd0,
		CFG_W_Y     = 3'd1,
		CFG_W_W     = 3'd2,
		CFG_W_H     = 3'd3,
		CFG_W_COLOR = 3'd4,
		CFG_THRESH  = 3'd5
	} cfg_addr_e;

	typedef enum logic [1:0] {
		ST_IDLE,  // waiting for a box
		ST_SCAN,  // issuing history reads
		ST_DRAIN, // waiting for the last score
		ST_OUT    // id presented, waiting for the handshake
	} match_state_e;

endpackage
